// File: common/ntt_tf_consts.svh
`ifndef NTT_TF_CONSTS_SVH
`define NTT_TF_CONSTS_SVH

// ----------------------------------------------------------
// datapath widths and modulus
// ----------------------------------------------------------
`define NTT_D_WIDTH      14
`define NTT_Q            12289

// barrett reduction, shift is twice the coefficient width
`define NTT_BARRETT_K    (2 * `NTT_D_WIDTH)
`define NTT_BARRETT_MU   21843          // floor(2^28 / 12289)

// ----------------------------------------------------------
// twiddle bank geometry
// ----------------------------------------------------------
`define NTT_TF_LANES     15             // lanes m = 1..15
`define NTT_TF_DEPTH     4              // one row per iteration depth
`define NTT_TF_CONSTS    14             // per-stage constant table

// constant index rule
`define NTT_LOG2_DEGREE  12
`define NTT_RADIX_K      4

// multiplier pipeline depth
`define NTT_MUL_LAT      3

`endif

// File: common/ntt_tf_pkg.sv
`default_nettype none

`include "ntt_tf_consts.svh"

package ntt_tf_pkg;

	// one residue mod q
	typedef logic [`NTT_D_WIDTH-1:0] coeff_t;

	// lane m sits at index m-1
	typedef coeff_t [`NTT_TF_LANES-1:0] tf_row_t;

	typedef coeff_t [`NTT_TF_CONSTS-1:0] tf_table_t;

	// row select
	typedef logic [$clog2(`NTT_TF_DEPTH)-1:0] depth_t;

	// radix-16 stage, 0..2 legal
	typedef logic [1:0] stage_t;

endpackage

`default_nettype wire

// File: common/tf_lane_if.sv
`timescale 1ns/1ns
`default_nettype none

interface tf_lane_if;
	import ntt_tf_pkg::*;

	// issue side
	logic    issue_valid;
	depth_t  issue_depth;
	tf_row_t issue_a;     // row operands
	tf_row_t issue_b;     // per-lane constants

	// result side
	logic    res_valid;
	depth_t  res_depth;
	tf_row_t res;

	modport bank (
		output issue_valid,
		output issue_depth,
		output issue_a,
		input  res_valid,
		input  res_depth,
		input  res
	);

	modport coef (
		output issue_b
	);

	modport lanes (
		input  issue_valid,
		input  issue_depth,
		input  issue_a,
		input  issue_b,
		output res_valid,
		output res_depth,
		output res
	);

endinterface

`default_nettype wire

// File: mod_mul/barrett_lane_array.sv
`timescale 1ns/1ns
`default_nettype none

`include "ntt_tf_consts.svh"

module barrett_lane_array (
	input  logic     clk,
	input  logic     rst,
	tf_lane_if.lanes lane
);
	import ntt_tf_pkg::*;

	localparam int LAT = `NTT_MUL_LAT;

	coeff_t         res_c  [`NTT_TF_LANES];
	logic [LAT-1:0] vld_sr;
	depth_t         dep_sr [LAT];

	// ----------------------------------------------------------
	// one multiplier per lane
	// ----------------------------------------------------------
	for (genvar m = 0; m < `NTT_TF_LANES; m++) begin : g_lane
		barrett_mul barrett_mul_i (
			.clk    (clk),
			.rst    (rst),
			.a      (lane.issue_a[m]),
			.b      (lane.issue_b[m]),
			.result (res_c[m])
		);
	end

	always_comb begin
		for (int i = 0; i < `NTT_TF_LANES; i++) begin
			lane.res[i] = res_c[i];
		end
	end

	// ----------------------------------------------------------
	// valid and depth tag, matched to the multiplier latency
	// ----------------------------------------------------------
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			vld_sr <= '0;
		end else begin
			vld_sr <= {vld_sr[LAT-2:0], lane.issue_valid};
		end
	end

	always_ff @(posedge clk) begin
		dep_sr[0] <= lane.issue_depth;
		for (int i = 1; i < LAT; i++) begin
			dep_sr[i] <= dep_sr[i-1];
		end
	end

	assign lane.res_valid = vld_sr[LAT-1];
	assign lane.res_depth = dep_sr[LAT-1]; // several updates in flight

endmodule

`default_nettype wire

// File: mod_mul/barrett_mul.sv
`timescale 1ns/1ns
`default_nettype none

`include "ntt_tf_consts.svh"

module barrett_mul (
	input  logic               clk,
	input  logic               rst,
	input  ntt_tf_pkg::coeff_t a,
	input  ntt_tf_pkg::coeff_t b,
	output ntt_tf_pkg::coeff_t result
);

	localparam int W  = `NTT_D_WIDTH;
	localparam int K  = `NTT_BARRETT_K;
	localparam int PW = 2 * W;      // product width
	localparam int MW = W + 1;      // mu fits in W+1 bits
	localparam int XW = PW + MW;

	localparam logic [MW-1:0] MU = MW'(`NTT_BARRETT_MU);
	localparam logic [W-1:0]  Q  = W'(`NTT_Q);

	logic [PW-1:0] prod_s1;
	logic [PW-1:0] prod_s2;
	logic [XW-1:0] prod_mu;
	logic [W-1:0]  quot_s2;
	logic [PW-1:0] quot_q;
	logic [W:0]    rem;
	logic [W:0]    rem_sub;

	// quotient estimate, at most one short
	assign prod_mu = {{MW{1'b0}}, prod_s1} * {{PW{1'b0}}, MU};

	// remainder below 2q, so W+1 bits are exact
	assign quot_q  = {{W{1'b0}}, quot_s2} * {{W{1'b0}}, Q};
	assign rem     = prod_s2[W:0] - quot_q[W:0];
	assign rem_sub = rem - {1'b0, Q};

	// ----------------------------------------------------------
	// three register stages
	// ----------------------------------------------------------
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			prod_s1 <= '0;
			prod_s2 <= '0;
			quot_s2 <= '0;
			result  <= '0;
		end else begin
			// stage 1: full product
			prod_s1 <= {{W{1'b0}}, a} * {{W{1'b0}}, b};
			// stage 2: floor(p * mu / 2^k)
			prod_s2 <= prod_s1;
			quot_s2 <= prod_mu[K +: W];
			// stage 3: one conditional correction
			if (rem >= {1'b0, Q}) begin
				result <= rem_sub[W-1:0];
			end else begin
				result <= rem[W-1:0];
			end
		end
	end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# build the testbench with verilator, run it, check the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert --timescale 1ns/1ns \
	-f verilog.f --top-module tb_ntt_tf_gen -Mdir "$OBJ" -o sim_tb
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$OBJ/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^>>> PASS$" "$LOG"; then
	exit 0
fi
echo "pass message not found in $LOG"
exit 1

// File: tf_gen/ntt_tf_gen.sv
`timescale 1ns/1ns
`default_nettype none

module ntt_tf_gen (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  tf_init_base,
	input  logic                  tf_init_const,
	input  logic                  tf_ren,
	input  logic                  tf_update,
	input  ntt_tf_pkg::depth_t    depth_sel,
	input  ntt_tf_pkg::stage_t    stage_sel,
	input  ntt_tf_pkg::tf_row_t   base_in,
	input  ntt_tf_pkg::tf_table_t const_in,
	output ntt_tf_pkg::tf_row_t   tf_out
);

	// operand / result bus between bank, selector and lanes
	tf_lane_if lane_bus ();

	// ----------------------------------------------------------
	// row storage and command decode
	// ----------------------------------------------------------
	tf_row_bank tf_row_bank_i (
		.clk          (clk),
		.rst          (rst),
		.tf_init_base (tf_init_base),
		.tf_ren       (tf_ren),
		.tf_update    (tf_update),
		.depth_sel    (depth_sel),
		.base_in      (base_in),
		.tf_out       (tf_out),
		.lane         (lane_bus.bank)
	);

	// ----------------------------------------------------------
	// constant table, per-lane select
	// ----------------------------------------------------------
	tf_const_select tf_const_select_i (
		.clk           (clk),
		.rst           (rst),
		.tf_init_const (tf_init_const),
		.tf_init_base  (tf_init_base),
		.tf_ren        (tf_ren),
		.tf_update     (tf_update),
		.stage_sel     (stage_sel),
		.const_in      (const_in),
		.lane          (lane_bus.coef)
	);

	// ----------------------------------------------------------
	// modular multiplier lanes
	// ----------------------------------------------------------
	barrett_lane_array barrett_lane_array_i (
		.clk  (clk),
		.rst  (rst),
		.lane (lane_bus.lanes)
	);

endmodule

`default_nettype wire

// File: tf_gen/tf_const_select.sv
`timescale 1ns/1ns
`default_nettype none

`include "ntt_tf_consts.svh"

module tf_const_select (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  tf_init_const,
	input  logic                  tf_init_base,
	input  logic                  tf_ren,
	input  logic                  tf_update,
	input  ntt_tf_pkg::stage_t    stage_sel,
	input  ntt_tf_pkg::tf_table_t const_in,
	tf_lane_if.coef               lane
);
	import ntt_tf_pkg::*;

	tf_table_t const_tbl;
	coeff_t    sel_c [`NTT_TF_LANES];
	logic      load_ok;

	// only a lone tf_init_const loads the table
	assign load_ok = ({tf_init_base, tf_init_const, tf_ren, tf_update} == 4'b0100);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			const_tbl <= '0;
		end else if (load_ok) begin
			const_tbl <= const_in;
		end
	end

	// ----------------------------------------------------------
	// per-lane index: LOG2_DEGREE - RADIX_K*stage - floor(log2 m)
	// ----------------------------------------------------------
	for (genvar m = 1; m <= `NTT_TF_LANES; m++) begin : g_sel
		localparam int GRP = $clog2(m + 1) - 1; // 0,1,1,2x4,3x8

		logic [5:0] idx;

		assign idx = 6'(`NTT_LOG2_DEGREE - GRP) - 6'(`NTT_RADIX_K) * {4'b0000, stage_sel};

		// illegal stage wraps negative, gives zero
		assign sel_c[m-1] = (idx < 6'(`NTT_TF_CONSTS)) ? const_tbl[idx[3:0]] : '0;
	end

	// registered every cycle, lines up with issue_valid
	always_ff @(posedge clk) begin
		for (int i = 0; i < `NTT_TF_LANES; i++) begin
			lane.issue_b[i] <= sel_c[i];
		end
	end

endmodule

`default_nettype wire

// File: tf_gen/tf_row_bank.sv
`timescale 1ns/1ns
`default_nettype none

`include "ntt_tf_consts.svh"

module tf_row_bank (
	input  logic                clk,
	input  logic                rst,
	input  logic                tf_init_base,
	input  logic                tf_ren,
	input  logic                tf_update,
	input  ntt_tf_pkg::depth_t  depth_sel,
	input  ntt_tf_pkg::tf_row_t base_in,
	output ntt_tf_pkg::tf_row_t tf_out,
	tf_lane_if.bank             lane
);
	import ntt_tf_pkg::*;

	tf_row_t rows [`NTT_TF_DEPTH];

	logic [2:0] cmd;
	logic       do_base;
	logic       do_read;
	logic       do_upd;

	// one-hot decode, anything else is idle
	assign cmd = {tf_init_base, tf_ren, tf_update};

	always_comb begin
		do_base = 1'b0;
		do_read = 1'b0;
		do_upd  = 1'b0;
		case (cmd)
			3'b100:  do_base = 1'b1;
			3'b010:  do_read = 1'b1;
			3'b001:  do_upd  = 1'b1;
			default: ;
		endcase
	end

	// ----------------------------------------------------------
	// row storage
	// ----------------------------------------------------------
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < `NTT_TF_DEPTH; i++) begin
				rows[i] <= '0;
			end
		end else begin
			if (do_base) begin
				rows[depth_sel] <= base_in;
			end
			// write-back lands last, wins on the same row
			if (lane.res_valid) begin
				rows[lane.res_depth] <= lane.res;
			end
		end
	end

	// ----------------------------------------------------------
	// read register
	// ----------------------------------------------------------
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			tf_out <= '0;
		end else if (do_read) begin
			tf_out <= rows[depth_sel];
		end else begin
			tf_out <= '0; // zero outside reads
		end
	end

	// ----------------------------------------------------------
	// update issue into the lanes
	// ----------------------------------------------------------
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			lane.issue_valid <= 1'b0;
		end else begin
			lane.issue_valid <= do_upd; // one-cycle pulse
		end
	end

	always_ff @(posedge clk) begin
		if (do_upd) begin
			lane.issue_a     <= rows[depth_sel];
			lane.issue_depth <= depth_sel; // tag travels with the data
		end
	end

endmodule

`default_nettype wire

// File: verification/tb_ntt_tf_gen.sv
`timescale 1ns/1ns
`default_nettype none

`include "ntt_tf_consts.svh"

module tb_ntt_tf_gen;
	import ntt_tf_pkg::*;

	localparam int CLK_HALF = 10;

	// cycle budget of each test, the watchdog runs on the sum
	localparam int RESET_CYC  = 4;
	localparam int T1_CYC     = 20;
	localparam int T2_CYC     = 12;
	localparam int T3_CYC     = 80;
	localparam int T4_CYC     = 20;
	localparam int T5_CYC     = 70;
	localparam int MARGIN_CYC = 50;
	localparam int RUN_CYC    = RESET_CYC + T1_CYC + T2_CYC + T3_CYC + T4_CYC + T5_CYC
		+ MARGIN_CYC;

	logic      clk;
	logic      rst;
	logic      tf_init_base;
	logic      tf_init_const;
	logic      tf_ren;
	logic      tf_update;
	depth_t    depth_sel;
	stage_t    stage_sel;
	tf_row_t   base_in;
	tf_table_t const_in;
	tf_row_t   tf_out;

	integer    seed;
	int        errors;
	int        checks;
	string     test_name;

	tf_row_t   ref_rows [`NTT_TF_DEPTH]; // model of the row bank
	tf_table_t ref_tbl;

	tf_row_t   next_exp;  // expected tf_out for the command now driven
	string     next_name;
	tf_row_t   chk_row;   // expected tf_out after the last edge
	string     chk_name;

	ntt_tf_gen ntt_tf_gen_i (
		.clk           (clk),
		.rst           (rst),
		.tf_init_base  (tf_init_base),
		.tf_init_const (tf_init_const),
		.tf_ren        (tf_ren),
		.tf_update     (tf_update),
		.depth_sel     (depth_sel),
		.stage_sel     (stage_sel),
		.base_in       (base_in),
		.const_in      (const_in),
		.tf_out        (tf_out)
	);

	initial begin
		clk = 1'b0;
		forever #CLK_HALF clk = ~clk;
	end

	// ------------------------------------------------------------
	// reference model
	// ------------------------------------------------------------
	function automatic tf_row_t updated_row(tf_row_t old_row, tf_table_t tbl, stage_t st);
		tf_row_t         nr;
		int              grp;
		int              idx;
		longint unsigned prod;
		for (int m = 1; m <= `NTT_TF_LANES; m++) begin
			grp = 0;
			while ((2 << grp) <= m) grp++; // floor(log2 m)
			idx = `NTT_LOG2_DEGREE - `NTT_RADIX_K * int'(st) - grp;
			prod = 64'(old_row[m-1]) * 64'(tbl[idx]);
			nr[m-1] = coeff_t'(prod % 64'(`NTT_Q));
		end
		return nr;
	endfunction

	function automatic tf_row_t random_row();
		tf_row_t r;
		for (int m = 0; m < `NTT_TF_LANES; m++) begin
			r[m] = coeff_t'($unsigned($random(seed)) % `NTT_Q);
		end
		return r;
	endfunction

	function automatic tf_table_t random_table();
		tf_table_t t;
		for (int i = 0; i < `NTT_TF_CONSTS; i++) begin
			t[i] = coeff_t'($unsigned($random(seed)) % `NTT_Q);
		end
		return t;
	endfunction

	// ------------------------------------------------------------
	// stimulus, one clock per call
	// ------------------------------------------------------------
	task automatic clear_cmd();
		tf_init_base  <= 1'b0;
		tf_init_const <= 1'b0;
		tf_ren        <= 1'b0;
		tf_update     <= 1'b0;
		next_exp      <= '0;
		next_name     <= test_name;
	endtask

	task automatic idle_cycles(int n);
		repeat (n) begin
			@(posedge clk);
			clear_cmd();
		end
	endtask

	task automatic load_row(depth_t d, tf_row_t row);
		@(posedge clk);
		clear_cmd();
		tf_init_base <= 1'b1;
		depth_sel    <= d;
		base_in      <= row;
		ref_rows[d] = row;
	endtask

	task automatic load_table(tf_table_t t);
		@(posedge clk);
		clear_cmd();
		tf_init_const <= 1'b1;
		const_in      <= t;
		ref_tbl = t;
	endtask

	task automatic read_row(depth_t d);
		@(posedge clk);
		clear_cmd();
		tf_ren    <= 1'b1;
		depth_sel <= d;
		next_exp  <= ref_rows[d];
	endtask

	task automatic start_update(depth_t d, stage_t st);
		@(posedge clk);
		clear_cmd();
		tf_update <= 1'b1;
		depth_sel <= d;
		stage_sel <= st;
		ref_rows[d] = updated_row(ref_rows[d], ref_tbl, st);
	endtask

	// several strobes at once, neither bank nor table may change
	task automatic collide_row(depth_t d, tf_row_t row);
		@(posedge clk);
		clear_cmd();
		tf_init_base <= 1'b1;
		tf_ren       <= 1'b1;
		depth_sel    <= d;
		base_in      <= row;
	endtask

	task automatic collide_table(tf_table_t t);
		@(posedge clk);
		clear_cmd();
		tf_init_const <= 1'b1;
		tf_init_base  <= 1'b1;
		tf_ren        <= 1'b1;
		const_in      <= t;
		base_in       <= random_row();
	endtask

	// ------------------------------------------------------------
	// compare
	// ------------------------------------------------------------
	always @(posedge clk) begin
		chk_row  <= next_exp;
		chk_name <= next_name;
	end

	always @(negedge clk) begin
		if (!rst) begin
			checks++;
			assert (tf_out == chk_row) else begin
				errors++;
				$display("ERR %s: expected %h, actual %h", chk_name, chk_row, tf_out);
			end
			for (int m = 0; m < `NTT_TF_LANES; m++) begin
				assert (tf_out[m] < `NTT_Q) else begin
					errors++;
					$display("%s: lane %0d of tf_out is not reduced below q", chk_name, m + 1);
				end
			end
		end
	end

	initial begin
		#(RUN_CYC * 2 * CLK_HALF);
		$display("timeout: run did not finish within %0d cycles", RUN_CYC);
		$display(">>> FAIL");
		$finish;
	end

	// ------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------
	initial begin
		tf_row_t   near_row;
		tf_table_t near_tbl;
		seed          = 32'h5b8b;
		errors        = 0;
		checks        = 0;
		test_name     = "reset";
		rst           = 1'b1;
		tf_init_base  = 1'b0;
		tf_init_const = 1'b0;
		tf_ren        = 1'b0;
		tf_update     = 1'b0;
		depth_sel     = '0;
		stage_sel     = '0;
		base_in       = '0;
		const_in      = '0;
		next_exp      = '0;
		next_name     = test_name;
		ref_tbl       = '0;
		for (int d = 0; d < `NTT_TF_DEPTH; d++) ref_rows[d] = '0;
		repeat (RESET_CYC) @(posedge clk);
		rst <= 1'b0;

		test_name = "reset_idle"; // rows zero, collisions ignored
		idle_cycles(3);
		for (int d = 0; d < `NTT_TF_DEPTH; d++) read_row(depth_t'(d));
		load_row(2'd0, random_row());
		collide_row(2'd0, random_row());
		read_row(2'd0);

		test_name = "load_read";
		for (int d = 0; d < `NTT_TF_DEPTH; d++) load_row(depth_t'(d), random_row());
		for (int d = 0; d < `NTT_TF_DEPTH; d++) read_row(depth_t'(d));

		test_name = "update_stages";
		load_table(random_table());
		collide_table(random_table());
		for (int s = 0; s < 3; s++) begin
			for (int d = 0; d < `NTT_TF_DEPTH; d++) begin
				start_update(depth_t'(d), stage_t'(s));
				idle_cycles(4); // read lands 5 edges after the update
				read_row(depth_t'(d));
			end
		end

		test_name = "update_burst"; // back to back, tags must stay apart
		for (int d = 0; d < `NTT_TF_DEPTH; d++) start_update(depth_t'(d), stage_t'(d % 3));
		idle_cycles(4);
		for (int d = 0; d < `NTT_TF_DEPTH; d++) read_row(depth_t'(d));

		test_name = "update_chain";
		for (int m = 0; m < `NTT_TF_LANES; m++) near_row[m] = coeff_t'(`NTT_Q - 1 - m);
		for (int i = 0; i < `NTT_TF_CONSTS; i++) near_tbl[i] = coeff_t'(`NTT_Q - 1 - 2 * i);
		load_row(2'd2, near_row);
		load_table(near_tbl);
		for (int k = 0; k < 10; k++) begin
			start_update(2'd2, stage_t'(k % 3));
			idle_cycles(4);
			read_row(2'd2);
		end
		idle_cycles(2);

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+common
common/ntt_tf_pkg.sv
common/tf_lane_if.sv
mod_mul/barrett_mul.sv
mod_mul/barrett_lane_array.sv
tf_gen/tf_row_bank.sv
tf_gen/tf_const_select.sv
tf_gen/ntt_tf_gen.sv
verification/tb_ntt_tf_gen.sv
